/* conv_pkg.sv */
`default_nettype none

package conv_pkg;

	// ----------------------------------------
	// Image geometry
	// ----------------------------------------

	// 16x16 input image with two pixels per word
	localparam int IMG_ROWS          = 16;
	localparam int IN_WORDS_PER_ROW  = 8;

	// 14x14 result with two clipped bytes per word
	localparam int OUT_WORDS_PER_ROW = 7;
	localparam int OUT_WORDS         = 98;

	// Upper ReLU clip bound
	localparam int RELU_MAX          = 127;

	// Input word column where the last window pair starts
	localparam int LAST_COL_WORD     = 6;

	// ----------------------------------------
	// Data types
	// ----------------------------------------

	// Pixel or kernel tap
	typedef logic signed [7:0]  pixel_t;
	// Wrapping 16-bit sum
	typedef logic signed [15:0] acc_t;
	typedef logic [11:0]        sram_addr_t;
	typedef logic [15:0]        sram_word_t;

	// Taps K0..K8 with K0 at window row 0 column 0
	typedef pixel_t [8:0] kernel_t;

	// Scan controller states
	typedef enum logic [3:0] {
		IDLE    = 4'd0,
		PREP0   = 4'd1,
		PREP1   = 4'd2,
		S0_INIT = 4'd4,
		S0      = 4'd3,
		S1      = 4'd5,
		S2      = 4'd6,
		S3      = 4'd7,
		S4      = 4'd8,
		S5      = 4'd9,
		S6      = 4'd10,
		S7      = 4'd11
	} conv_state_e;

endpackage

`default_nettype wire

/* conv_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module conv_ctrl (
	input  logic                  clk,
	input  logic                  reset_b,
	input  logic                  dut_run,
	input  logic                  scan_done,
	output conv_pkg::conv_state_e state,
	output logic                  dut_busy
);

	conv_pkg::conv_state_e state_nxt;

	// ----------------------------------------
	// Next state
	// ----------------------------------------

	// Fixed sequence, PREP0 -> PREP1 -> S0_INIT -> S1..S7 -> S0 -> S1 ...
	always_comb begin
		state_nxt = state;
		case (state)
			conv_pkg::IDLE: begin
				// Start level sampled only here
				if (dut_run) begin
					state_nxt = conv_pkg::PREP0;
				end
			end
			conv_pkg::PREP0:   state_nxt = conv_pkg::PREP1;
			conv_pkg::PREP1:   state_nxt = conv_pkg::S0_INIT;
			conv_pkg::S0_INIT: state_nxt = conv_pkg::S1;
			conv_pkg::S1:      state_nxt = conv_pkg::S2;
			conv_pkg::S2:      state_nxt = conv_pkg::S3;
			conv_pkg::S3:      state_nxt = conv_pkg::S4;
			conv_pkg::S4:      state_nxt = conv_pkg::S5;
			conv_pkg::S5:      state_nxt = conv_pkg::S6;
			conv_pkg::S6:      state_nxt = conv_pkg::S7;
			conv_pkg::S7:      state_nxt = conv_pkg::S0;
			conv_pkg::S0: begin
				// Last output word goes out in this S0
				if (scan_done) begin
					state_nxt = conv_pkg::IDLE;
				end else begin
					state_nxt = conv_pkg::S1;
				end
			end
			default:           state_nxt = conv_pkg::IDLE;
		endcase
	end

	// State register
	always_ff @(posedge clk) begin
		if (!reset_b) begin
			state <= conv_pkg::IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Busy in every state but IDLE
	assign dut_busy = (state != conv_pkg::IDLE);

endmodule

`default_nettype wire

/* scan_addr_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module scan_addr_gen (
	input  logic                  clk,
	input  logic                  reset_b,
	input  conv_pkg::conv_state_e state,
	output conv_pkg::sram_addr_t  input_sram_read_address,
	output conv_pkg::sram_addr_t  output_sram_write_address,
	output logic                  scan_done
);

	// Row and word column of the current read address
	conv_pkg::sram_addr_t in_row;
	conv_pkg::sram_addr_t in_col;
	// Last row pair of this word column is in flight
	logic                 col_end;

	assign in_row = input_sram_read_address
		/ conv_pkg::sram_addr_t'(conv_pkg::IN_WORDS_PER_ROW);
	assign in_col = input_sram_read_address
		% conv_pkg::sram_addr_t'(conv_pkg::IN_WORDS_PER_ROW);

	// ----------------------------------------
	// Input read address
	// ----------------------------------------

	// Alternates +1 along the word and +7 down to the next row
	always_ff @(posedge clk) begin
		if (!reset_b) begin
			input_sram_read_address <= '0;
		end else begin
			case (state)
				conv_pkg::IDLE: input_sram_read_address <= '0;
				conv_pkg::PREP0, conv_pkg::S0_INIT, conv_pkg::S0,
				conv_pkg::S2, conv_pkg::S4, conv_pkg::S6: begin
					input_sram_read_address <= input_sram_read_address
						+ conv_pkg::sram_addr_t'(1);
				end
				conv_pkg::PREP1, conv_pkg::S1, conv_pkg::S3, conv_pkg::S7: begin
					input_sram_read_address <= input_sram_read_address
						+ conv_pkg::sram_addr_t'(conv_pkg::IN_WORDS_PER_ROW - 1);
				end
				conv_pkg::S5: begin
					// Back to top of next word column, or up one row pair
					if (col_end) begin
						input_sram_read_address <= input_sram_read_address
							- conv_pkg::sram_addr_t'((conv_pkg::IMG_ROWS - 1)
							* conv_pkg::IN_WORDS_PER_ROW);
					end else begin
						input_sram_read_address <= input_sram_read_address
							- conv_pkg::sram_addr_t'(conv_pkg::IN_WORDS_PER_ROW + 1);
					end
				end
				default: ;
			endcase
		end
	end

	// ----------------------------------------
	// Output write address
	// ----------------------------------------

	// Walks down one output word column, S6 and S0 each write one row
	always_ff @(posedge clk) begin
		if (!reset_b) begin
			output_sram_write_address <= '0;
		end else begin
			case (state)
				conv_pkg::IDLE, conv_pkg::PREP1, conv_pkg::S0_INIT: begin
					output_sram_write_address <= '0;
				end
				conv_pkg::S6: begin
					output_sram_write_address <= output_sram_write_address
						+ conv_pkg::sram_addr_t'(conv_pkg::OUT_WORDS_PER_ROW);
				end
				conv_pkg::S0: begin
					// From the bottom row back to row 0, one word to the right
					if (col_end) begin
						output_sram_write_address <= output_sram_write_address
							- conv_pkg::sram_addr_t'(conv_pkg::OUT_WORDS
							- conv_pkg::OUT_WORDS_PER_ROW - 1);
					end else begin
						output_sram_write_address <= output_sram_write_address
							+ conv_pkg::sram_addr_t'(conv_pkg::OUT_WORDS_PER_ROW);
					end
				end
				default: ;
			endcase
		end
	end

	// Column end and scan end, sampled on the bottom input row in S4
	always_ff @(posedge clk) begin
		if (!reset_b) begin
			col_end   <= 1'b0;
			scan_done <= 1'b0;
		end else begin
			case (state)
				conv_pkg::IDLE, conv_pkg::S0_INIT, conv_pkg::S0: begin
					col_end   <= 1'b0;
					scan_done <= 1'b0;
				end
				conv_pkg::S4: begin
					col_end   <= (in_row == conv_pkg::sram_addr_t'(conv_pkg::IMG_ROWS - 1));
					scan_done <= (in_row == conv_pkg::sram_addr_t'(conv_pkg::IMG_ROWS - 1))
						&& (in_col >= conv_pkg::sram_addr_t'(conv_pkg::LAST_COL_WORD));
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* kernel_loader.sv */
`timescale 1ns/1ns
`default_nettype none

module kernel_loader (
	input  logic                  clk,
	input  conv_pkg::conv_state_e state,
	input  conv_pkg::sram_word_t  weights_sram_read_data,
	output conv_pkg::sram_addr_t  weights_sram_read_address,
	output conv_pkg::kernel_t     kernel
);

	// ----------------------------------------
	// Weight word address
	// ----------------------------------------

	// One word ahead of the state that loads it
	always_comb begin
		case (state)
			conv_pkg::IDLE:                 weights_sram_read_address = 12'd0;
			conv_pkg::PREP0:                weights_sram_read_address = 12'd1;
			conv_pkg::PREP1:                weights_sram_read_address = 12'd2;
			conv_pkg::S0_INIT, conv_pkg::S0: weights_sram_read_address = 12'd3;
			conv_pkg::S1:                   weights_sram_read_address = 12'd4;
			// S7 fetches word 2 again for the S0 reload of K4/K5
			default:                        weights_sram_read_address = 12'd2;
		endcase
	end

	// Tap pairs loaded as the word arrives, high byte first
	always_ff @(posedge clk) begin
		case (state)
			conv_pkg::PREP0: begin
				kernel[0] <= weights_sram_read_data[15:8];
				kernel[1] <= weights_sram_read_data[7:0];
			end
			conv_pkg::PREP1: begin
				kernel[2] <= weights_sram_read_data[15:8];
				kernel[3] <= weights_sram_read_data[7:0];
			end
			conv_pkg::S0_INIT, conv_pkg::S0: begin
				kernel[4] <= weights_sram_read_data[15:8];
				kernel[5] <= weights_sram_read_data[7:0];
			end
			conv_pkg::S1: begin
				kernel[6] <= weights_sram_read_data[15:8];
				kernel[7] <= weights_sram_read_data[7:0];
			end
			// K8 alone in the high byte of word 4
			conv_pkg::S2: kernel[8] <= weights_sram_read_data[15:8];
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* mac_array.sv */
`timescale 1ns/1ns
`default_nettype none

module mac_array (
	input  logic                  clk,
	input  conv_pkg::conv_state_e state,
	input  conv_pkg::kernel_t     kernel,
	input  conv_pkg::sram_word_t  input_sram_read_data,
	output logic                  output_sram_write_enable,
	output conv_pkg::sram_word_t  output_sram_write_data
);

	// Pixel pair, i0 is the even column
	conv_pkg::pixel_t i0;
	conv_pkg::pixel_t i1;

	// Position inside the eight-state cycle
	logic [2:0] phase;
	logic       in_cycle;

	// Triple 0 feeds C0/C1, triple 1 feeds C2/C3
	conv_pkg::pixel_t tap_lo [2];
	conv_pkg::pixel_t tap_hi [2];
	logic             route_l [2];
	logic             clear [2];

	// C0..C3
	conv_pkg::acc_t acc [4];
	conv_pkg::acc_t acc_nxt [4];

	// ReLU with upper clamp
	function automatic logic [7:0] relu(input conv_pkg::acc_t v);
		if (v < 0) begin
			return 8'd0;
		end else if (v > conv_pkg::acc_t'(conv_pkg::RELU_MAX)) begin
			return 8'(conv_pkg::RELU_MAX);
		end
		return v[7:0];
	endfunction

	// Read data lands one cycle after the address, held one more here
	always_ff @(posedge clk) begin
		i0 <= input_sram_read_data[15:8];
		i1 <= input_sram_read_data[7:0];
	end

	// ----------------------------------------
	// Tap schedule
	// ----------------------------------------

	// S0_INIT and S0 share phase 0
	always_comb begin
		in_cycle = 1'b1;
		phase    = 3'd0;
		case (state)
			conv_pkg::S0_INIT, conv_pkg::S0: phase = 3'd0;
			conv_pkg::S1: phase = 3'd1;
			conv_pkg::S2: phase = 3'd2;
			conv_pkg::S3: phase = 3'd3;
			conv_pkg::S4: phase = 3'd4;
			conv_pkg::S5: phase = 3'd5;
			conv_pkg::S6: phase = 3'd6;
			conv_pkg::S7: phase = 3'd7;
			default: in_cycle = 1'b0;
		endcase
	end

	// Six steps per triple, triple 1 trails by two states
	// Even step: taps Kn,Kn+1 routed left; odd step: Kn,Kn+1 routed right
	always_comb begin
		int step;
		int base;
		for (int t = 0; t < 2; t++) begin
			step       = int'(phase) - 2 * t;
			base       = 3 * (step / 2) + step % 2;
			route_l[t] = (step % 2) == 0;
			tap_lo[t]  = '0;
			tap_hi[t]  = '0;
			if (in_cycle && step >= 0 && step <= 5) begin
				tap_lo[t] = kernel[4'(base)];
				tap_hi[t] = kernel[4'(base + 1)];
			end
		end
	end

	// C0/C1 restart after their S6 write, C2/C3 after their S0 write
	always_comb begin
		clear[0] = (state == conv_pkg::IDLE) || (state == conv_pkg::S7);
		clear[1] = (state == conv_pkg::IDLE) || (state == conv_pkg::S1);
	end

	// ----------------------------------------
	// Multipliers and accumulators
	// ----------------------------------------

	always_comb begin
		conv_pkg::pixel_t k_a;
		conv_pkg::acc_t   p_left;
		conv_pkg::acc_t   p_right;
		conv_pkg::acc_t   p_cross;
		for (int t = 0; t < 2; t++) begin
			k_a     = route_l[t] ? tap_lo[t] : tap_hi[t];
			p_left  = i0 * k_a;
			p_right = i1 * k_a;
			// Shared cross product
			if (route_l[t]) begin
				p_cross = i1 * tap_hi[t];
			end else begin
				p_cross = i0 * tap_lo[t];
			end
			if (clear[t]) begin
				acc_nxt[2 * t]     = '0;
				acc_nxt[2 * t + 1] = '0;
			end else if (route_l[t]) begin
				acc_nxt[2 * t]     = acc[2 * t] + p_left + p_cross;
				acc_nxt[2 * t + 1] = acc[2 * t + 1] + p_right;
			end else begin
				acc_nxt[2 * t]     = acc[2 * t] + p_left;
				acc_nxt[2 * t + 1] = acc[2 * t + 1] + p_right + p_cross;
			end
		end
	end

	// sums wrap at 16 bits
	always_ff @(posedge clk) begin
		acc <= acc_nxt;
	end

	// Even output row in S6, odd output row in S0
	always_comb begin
		output_sram_write_enable = 1'b0;
		output_sram_write_data   = '0;
		case (state)
			conv_pkg::S6: begin
				output_sram_write_enable = 1'b1;
				output_sram_write_data   = {relu(acc[0]), relu(acc[1])};
			end
			conv_pkg::S0: begin
				output_sram_write_enable = 1'b1;
				output_sram_write_data   = {relu(acc[2]), relu(acc[3])};
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* conv_top.sv */
`timescale 1ns/1ns
`default_nettype none

module conv_top (
	input  logic                 clk,
	input  logic                 reset_b,

	// Control
	input  logic                 dut_run,
	output logic                 dut_busy,

	// Input SRAM, read only
	output conv_pkg::sram_addr_t input_sram_read_address,
	input  conv_pkg::sram_word_t input_sram_read_data,

	// Weights SRAM, read only
	output conv_pkg::sram_addr_t weights_sram_read_address,
	input  conv_pkg::sram_word_t weights_sram_read_data,

	// Output SRAM, write only
	output logic                 output_sram_write_enable,
	output conv_pkg::sram_addr_t output_sram_write_address,
	output conv_pkg::sram_word_t output_sram_write_data
);

	conv_pkg::conv_state_e state;
	logic                  scan_done;
	conv_pkg::kernel_t     kernel;

	// ----------------------------------------
	// Controller
	// ----------------------------------------

	conv_ctrl u_ctrl (
		.clk       (clk),
		.reset_b   (reset_b),
		.dut_run   (dut_run),
		.scan_done (scan_done),
		.state     (state),
		.dut_busy  (dut_busy)
	);

	// Read and write address stepping
	scan_addr_gen u_addr (
		.clk                       (clk),
		.reset_b                   (reset_b),
		.state                     (state),
		.input_sram_read_address   (input_sram_read_address),
		.output_sram_write_address (output_sram_write_address),
		.scan_done                 (scan_done)
	);

	// ----------------------------------------
	// Datapath
	// ----------------------------------------

	kernel_loader u_kernel (
		.clk                       (clk),
		.state                     (state),
		.weights_sram_read_data    (weights_sram_read_data),
		.weights_sram_read_address (weights_sram_read_address),
		.kernel                    (kernel)
	);

	mac_array u_mac (
		.clk                      (clk),
		.state                    (state),
		.kernel                   (kernel),
		.input_sram_read_data     (input_sram_read_data),
		.output_sram_write_enable (output_sram_write_enable),
		.output_sram_write_data   (output_sram_write_data)
	);

endmodule

`default_nettype wire

/* tb_conv_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_conv_mem (
	input  logic                 clk,

	// Input image port
	input  conv_pkg::sram_addr_t input_sram_read_address,
	output conv_pkg::sram_word_t input_sram_read_data,

	// Kernel port
	input  conv_pkg::sram_addr_t weights_sram_read_address,
	output conv_pkg::sram_word_t weights_sram_read_data,

	// Result port
	input  logic                 output_sram_write_enable,
	input  conv_pkg::sram_addr_t output_sram_write_address,
	input  conv_pkg::sram_word_t output_sram_write_data
);

	// ----------------------------------------
	// Storage, full 12-bit address space
	// ----------------------------------------

	// Filled by the testbench top
	conv_pkg::sram_word_t in_mem      [1 << $bits(conv_pkg::sram_addr_t)];
	conv_pkg::sram_word_t weights_mem [1 << $bits(conv_pkg::sram_addr_t)];
	// Written only by the DUT
	conv_pkg::sram_word_t out_mem     [1 << $bits(conv_pkg::sram_addr_t)];

	// Registered reads, data one cycle after the address
	always @(posedge clk) begin
		input_sram_read_data <= in_mem[input_sram_read_address];
	end

	always @(posedge clk) begin
		weights_sram_read_data <= weights_mem[weights_sram_read_address];
	end

	// Write on the edge that sees the enable
	always @(posedge clk) begin
		if (output_sram_write_enable) begin
			out_mem[output_sram_write_address] <= output_sram_write_data;
		end
	end

endmodule

`default_nettype wire

/* tb_conv.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_conv;

	logic                 clk;
	logic                 reset_b;
	logic                 dut_run;
	logic                 dut_busy;
	conv_pkg::sram_addr_t input_sram_read_address;
	conv_pkg::sram_word_t input_sram_read_data;
	conv_pkg::sram_addr_t weights_sram_read_address;
	conv_pkg::sram_word_t weights_sram_read_data;
	logic                 output_sram_write_enable;
	conv_pkg::sram_addr_t output_sram_write_address;
	conv_pkg::sram_word_t output_sram_write_data;

	// Model image and kernel, K0 at window row 0 column 0
	conv_pkg::pixel_t img [conv_pkg::IMG_ROWS][2 * conv_pkg::IN_WORDS_PER_ROW];
	conv_pkg::pixel_t kern [9];

	logic [31:0] lfsr = 32'hc5dd3f9a;
	logic        checks_on;
	int          check_errors;
	int          bus_errors;
	int          runs_done;
	int          cycle_count;
	// Writes seen per output word, one per completed run
	int          write_count [conv_pkg::OUT_WORDS];
	// Four runs of 8 cycles per row pair, doubled, plus slack for reset and gaps
	int          cycle_limit = 4 * 2 * 8 * ((conv_pkg::IMG_ROWS - 2) / 2)
		* conv_pkg::OUT_WORDS_PER_ROW + 500;

	conv_top uut (
		.clk                       (clk),
		.reset_b                   (reset_b),
		.dut_run                   (dut_run),
		.dut_busy                  (dut_busy),
		.input_sram_read_address   (input_sram_read_address),
		.input_sram_read_data      (input_sram_read_data),
		.weights_sram_read_address (weights_sram_read_address),
		.weights_sram_read_data    (weights_sram_read_data),
		.output_sram_write_enable  (output_sram_write_enable),
		.output_sram_write_address (output_sram_write_address),
		.output_sram_write_data    (output_sram_write_data)
	);

	tb_conv_mem mem (
		.clk                       (clk),
		.input_sram_read_address   (input_sram_read_address),
		.input_sram_read_data      (input_sram_read_data),
		.weights_sram_read_address (weights_sram_read_address),
		.weights_sram_read_data    (weights_sram_read_data),
		.output_sram_write_enable  (output_sram_write_enable),
		.output_sram_write_address (output_sram_write_address),
		.output_sram_write_data    (output_sram_write_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Watchdog
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout: no finish within %0d cycles, busy stuck or scan too long",
				cycle_limit);
			$display("Something failed");
			$finish;
		end
	end

	// ----------------------------------------
	// Output bus checks
	// ----------------------------------------

	assert property (@(posedge clk) disable iff (!checks_on)
		!(output_sram_write_enable && !dut_busy))
	else begin
		bus_errors++;
		$display("Fail at %0t: output write while busy is low", $time);
	end

	assert property (@(posedge clk) disable iff (!checks_on)
		!output_sram_write_enable
		|| (output_sram_write_address < conv_pkg::sram_addr_t'(conv_pkg::OUT_WORDS)))
	else begin
		bus_errors++;
		$display("Fail at %0t: write address %0d past the output image", $time,
			output_sram_write_address);
	end

	// Mid-cycle sample of the write that lands on the next rising edge
	always @(negedge clk) begin
		if (checks_on && output_sram_write_enable
			&& output_sram_write_address < conv_pkg::sram_addr_t'(conv_pkg::OUT_WORDS)) begin
			write_count[int'(output_sram_write_address)]++;
		end
	end

	// Galois form, right shift
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'ha3000000;
		end
		return s >> 1;
	endfunction

	// One LFSR step per bit
	task automatic take_byte(output logic [7:0] b);
		b = '0;
		for (int i = 0; i < 8; i++) begin
			b = {b[6:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// Reference for output row r, word p, from the window sums
	function automatic conv_pkg::sram_word_t expected_word(input int r, input int p);
		int             sum;
		int             c;
		conv_pkg::acc_t s;
		logic [7:0]     res [2];
		for (int h = 0; h < 2; h++) begin
			c = 2 * p + h;
			sum = 0;
			for (int n = 0; n < 9; n++) begin
				sum += int'(img[r + n / 3][c + n % 3]) * int'(kern[n]);
			end
			// Keep 16 bits two's complement, then clip
			s = conv_pkg::acc_t'(sum);
			if (s < 0) begin
				res[h] = 8'd0;
			end else if (s > conv_pkg::RELU_MAX) begin
				res[h] = 8'(conv_pkg::RELU_MAX);
			end else begin
				res[h] = s[7:0];
			end
		end
		// Even column in the high byte
		return {res[0], res[1]};
	endfunction

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------

	// Every word gets a value tied to all 12 address bits
	task automatic background_fill();
		conv_pkg::sram_addr_t ad;
		for (int a = 0; a < (1 << $bits(conv_pkg::sram_addr_t)); a++) begin
			ad = conv_pkg::sram_addr_t'(a);
			mem.in_mem[a]      = {ad, ad[11:8]} ^ 16'h5a3c;
			mem.weights_mem[a] = {ad[3:0], ad} ^ 16'hc3a5;
		end
	endtask

	task automatic random_image(input logic positive);
		logic [7:0] b;
		for (int r = 0; r < conv_pkg::IMG_ROWS; r++) begin
			for (int c = 0; c < 2 * conv_pkg::IN_WORDS_PER_ROW; c++) begin
				take_byte(b);
				img[r][c] = positive ? {1'b0, b[6:0]} : b;
			end
		end
	endtask

	task automatic constant_image(input conv_pkg::pixel_t v);
		for (int r = 0; r < conv_pkg::IMG_ROWS; r++) begin
			for (int c = 0; c < 2 * conv_pkg::IN_WORDS_PER_ROW; c++) begin
				img[r][c] = v;
			end
		end
	endtask

	task automatic random_kernel();
		logic [7:0] b;
		for (int n = 0; n < 9; n++) begin
			take_byte(b);
			kern[n] = b;
		end
	endtask

	task automatic constant_kernel(input conv_pkg::pixel_t v);
		for (int n = 0; n < 9; n++) begin
			kern[n] = v;
		end
	endtask

	// Two pixels per word, high byte first
	task automatic write_memories();
		for (int r = 0; r < conv_pkg::IMG_ROWS; r++) begin
			for (int w = 0; w < conv_pkg::IN_WORDS_PER_ROW; w++) begin
				mem.in_mem[r * conv_pkg::IN_WORDS_PER_ROW + w] = {img[r][2 * w],
					img[r][2 * w + 1]};
			end
		end
		for (int w = 0; w < 4; w++) begin
			mem.weights_mem[w] = {kern[2 * w], kern[2 * w + 1]};
		end
		// Low byte of word 4 unused
		mem.weights_mem[4] = {kern[8], 8'ha5};
	endtask

	// Busy must rise one cycle after the start level is seen
	task automatic start_run();
		@(negedge clk);
		assert (!dut_busy) else begin
			check_errors++;
			$display("Fail at %0t: busy high before start", $time);
		end
		dut_run = 1'b1;
		@(negedge clk);
		assert (dut_busy) else begin
			check_errors++;
			$display("Fail at %0t: busy did not rise after start", $time);
		end
		dut_run = 1'b0;
	endtask

	task automatic run_case(input string name);
		conv_pkg::sram_word_t exp_word;
		conv_pkg::sram_word_t got;
		write_memories();
		start_run();
		// Watchdog bounds this wait
		while (dut_busy) begin
			@(negedge clk);
		end
		runs_done++;
		for (int r = 0; r < conv_pkg::IMG_ROWS - 2; r++) begin
			for (int p = 0; p < conv_pkg::OUT_WORDS_PER_ROW; p++) begin
				exp_word = expected_word(r, p);
				got = mem.out_mem[r * conv_pkg::OUT_WORDS_PER_ROW + p];
				assert (got == exp_word) else begin
					check_errors++;
					$display("Fail at %0t: %s row %0d word %0d got %h expected %h",
						$time, name, r, p, got, exp_word);
				end
			end
		end
		// Exactly one write per word in each run
		for (int a = 0; a < conv_pkg::OUT_WORDS; a++) begin
			assert (write_count[a] == runs_done) else begin
				check_errors++;
				$display("Fail at %0t: %s word %0d written %0d times over %0d runs",
					$time, name, a, write_count[a], runs_done);
			end
		end
		$display("Case %s done at %0t", name, $time);
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------

	initial begin
		reset_b = 1'b0;
		dut_run = 1'b0;
		checks_on = 1'b0;
		check_errors = 0;
		bus_errors = 0;
		runs_done = 0;
		background_fill();
		repeat (4) @(negedge clk);
		reset_b = 1'b1;
		checks_on = 1'b1;

		// Quiet after reset while start stays low
		repeat (3) begin
			@(negedge clk);
			assert (!dut_busy && !output_sram_write_enable) else begin
				check_errors++;
				$display("Fail at %0t: busy or write enable high after reset", $time);
			end
		end

		random_image(1'b0);
		random_kernel();
		run_case("random");

		// 9 x 127 x 100 wraps negative in 16 bits
		constant_image(8'sd100);
		constant_kernel(8'sd127);
		run_case("wrapped sum");

		// Every window sum at or below zero
		random_image(1'b1);
		constant_kernel(-8'sd1);
		run_case("negative taps");

		// Fresh data, back to back with the earlier runs
		random_image(1'b0);
		random_kernel();
		run_case("second random");

		$display("Errors: %0d check, %0d bus", check_errors, bus_errors);
		if (check_errors == 0 && bus_errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
conv_pkg.sv
conv_ctrl.sv
scan_addr_gen.sv
kernel_loader.sv
mac_array.sv
conv_top.sv
tb_conv_mem.sv
tb_conv.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the convolution testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_conv -f project.f; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_conv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Something failed" "$LOG"; then
	exit 1
fi
exit 0
